// File: verification/decode_patterns.txt
# name inst0 inst1 dual w_ena0 w_dst0 cls0 w_ena1 w_dst1 cls1, all hex after the name
# cls bits: 0 branch 1 j 2 jr 3 ls 4 mul 5 hilo 6 cop0 7 tlb 8 cache 9 ov 10 reserved
add_rd        00221820 00C72821 1 1 03 200 1 05 000
addi_lw       20240005 8C490000 1 1 04 200 1 09 008
mfc0_rt       40076000 00C72821 0 1 07 040 1 05 000
jal_bgezal    0C000010 04910004 0 1 1F 002 1 1F 001
dst_zero      00220021 00C72821 1 0 00 000 1 05 000
sw_beq        AC430004 10220003 0 0 00 008 0 00 001
bgez_mult     04A10002 00220018 1 0 00 001 0 00 020
mtc0_jr       40836000 03E00008 0 0 00 040 0 00 004
syscall_tlbwi 0000000C 42000002 0 0 00 040 0 00 0C0
bltz_bgtz     04400001 1C600005 0 0 00 001 0 00 001
j_jalr        08000040 0080F809 0 0 00 002 1 1F 004
lwl_swr       88460000 B8670000 0 1 06 008 0 00 008
mul_mfhi      70222802 00004810 0 1 05 010 1 09 020
break_tlbp    0000000D 42000008 0 0 00 040 0 00 0C0
tlbr_cache    42000001 BC410000 0 0 00 0C0 0 00 100
sub_addu      00225022 00C72821 1 1 0A 200 1 05 000
ri_both       FC000000 00000001 0 0 00 400 0 00 400
raw_rs        012A4021 010C5821 0 1 08 000 1 0B 000
raw_rt        012A4021 01885821 0 1 08 000 1 0B 000
raw_none      012A4021 018D5821 1 1 08 000 1 0B 000
two_loads     8C490000 8C6A0004 0 1 09 008 1 0A 008
load_alu      8C490000 00C72821 1 1 09 008 1 05 000
mult_mfhi     00220018 00004810 0 0 00 020 1 09 020
mult_alu      00220018 00C72821 1 0 00 020 1 05 000
alu_branch    012A4021 10220003 0 1 08 000 0 00 001
branch_alu    10220003 00C72821 1 0 00 001 1 05 000
ri_slot0      FC000000 00C72821 0 0 00 400 1 05 000
ri_slot1      012A4021 00000001 0 1 08 000 0 00 400

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dual_decode_tb
BUILD_DIR ?= build
LOG       ?= sim.log
FLAGS     ?= -O2

SRCS := $(filter %.sv %.v,$(shell cat src.f))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): src.f $(SRCS)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f src.f --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: src.f
logic/decode_pkg.sv
logic/decode_if.sv
logic/inst_decoder.sv
logic/issue_pair.sv
logic/dual_decode_top.sv
verification/dual_decode_tb.sv

// File: verification/dual_decode_tb.sv
module dual_decode_tb
    import decode_pkg::*;
();

    typedef struct packed {
        logic [31:0]      inst0;
        logic [31:0]      inst1;
        logic             dual;
        logic             ena0;
        logic [4:0]       dst0;
        logic [CLS_W-1:0] cls0;
        logic             ena1;
        logic [4:0]       dst1;
        logic [CLS_W-1:0] cls1;
    } pattern_t;

    localparam string PAT_FILE     = "verification/decode_patterns.txt";
    localparam int    RESET_CYCLES = 8;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic [31:0]      inst0;
    logic [31:0]      inst1;
    logic             out_valid;
    logic             dual_issue;
    logic             w_ena0;
    logic [4:0]       w_dst0;
    logic [CLS_W-1:0] cls0;
    logic             w_ena1;
    logic [4:0]       w_dst1;
    logic [CLS_W-1:0] cls1;

    pattern_t    pats[$];
    string       names[$];
    string       cur_test;
    bit          test_bad;
    int          err_count;
    int          n_pass;
    int          n_fail;
    int          cycles;
    int          cycle_limit = RESET_CYCLES + 50;

    dual_decode_top #(
        .TLB_EN(1'b1)
    ) dual_decode_top_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .inst0      (inst0),
        .inst1      (inst1),
        .out_valid  (out_valid),
        .dual_issue (dual_issue),
        .w_ena0     (w_ena0),
        .w_dst0     (w_dst0),
        .cls0       (cls0),
        .w_ena1     (w_ena1),
        .w_dst1     (w_dst1),
        .cls1       (cls1)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ~~~~~~~~~~ helpers ~~~~~~~~~~~~
    task automatic compare_value(input string sig, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] t=%0t %s: %s expected %0h got %0h",
                     $time, cur_test, sig, exp, act);
            test_bad = 1'b1;
            err_count++;
        end
    endtask

    task automatic report_test();
        if (test_bad) begin
            n_fail++;
            $display("test %s: failed", cur_test);
        end else begin
            n_pass++;
            $display("test %s: passed", cur_test);
        end
        test_bad = 1'b0;
    endtask

    task automatic read_patterns();
        int       fd;
        int       n;
        string    line;
        string    name;
        logic [31:0] v[0:8];
        pattern_t p;
        fd = $fopen(PAT_FILE, "r");
        if (fd == 0) begin
            $display("cannot open pattern file %s", PAT_FILE);
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin     // skip comments and blanks.
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", name,
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                    if (n != 10) begin
                        $display("malformed pattern line: %s", line);
                        err_count++;
                    end else begin
                        p.inst0 = v[0];
                        p.inst1 = v[1];
                        p.dual  = v[2][0];
                        p.ena0  = v[3][0];
                        p.dst0  = v[4][4:0];
                        p.cls0  = v[5][CLS_W-1:0];
                        p.ena1  = v[6][0];
                        p.dst1  = v[7][4:0];
                        p.cls1  = v[8][CLS_W-1:0];
                        pats.push_back(p);
                        names.push_back(name);
                    end
                end
            end
            $fclose(fd);
        end
        if (pats.size() == 0) begin
            $display("no patterns were read");
            err_count++;
        end
    endtask

    task automatic check_outputs(input pattern_t p);
        compare_value("out_valid", 32'(1'b1), 32'(out_valid));
        compare_value("dual_issue", 32'(p.dual), 32'(dual_issue));
        compare_value("w_ena0", 32'(p.ena0), 32'(w_ena0));
        compare_value("w_dst0", 32'(p.dst0), 32'(w_dst0));
        compare_value("cls0", 32'(p.cls0), 32'(cls0));
        compare_value("w_ena1", 32'(p.ena1), 32'(w_ena1));
        compare_value("w_dst1", 32'(p.dst1), 32'(w_dst1));
        compare_value("cls1", 32'(p.cls1), 32'(cls1));
    endtask

    // words on the inputs are ignored while in_valid is low.
    task automatic idle_gap(input int unsigned len, input pattern_t last);
        in_valid = 1'b0;
        repeat (len) begin
            inst0 = $urandom;
            inst1 = $urandom;
            @(negedge clk);
        end
        cur_test = $sformatf("idle_%0d", len);
        compare_value("out_valid", 32'(1'b0), 32'(out_valid));
        compare_value("dual_issue", 32'(1'b0), 32'(dual_issue));
        compare_value("w_ena0", 32'(last.ena0), 32'(w_ena0));    // fields hold.
        compare_value("w_dst0", 32'(last.dst0), 32'(w_dst0));
        compare_value("cls0", 32'(last.cls0), 32'(cls0));
        compare_value("w_ena1", 32'(last.ena1), 32'(w_ena1));
        compare_value("w_dst1", 32'(last.dst1), 32'(w_dst1));
        compare_value("cls1", 32'(last.cls1), 32'(cls1));
        report_test();
    endtask

    // ~~~~~~~~~~ main sequence ~~~~~~
    initial begin
        int unsigned gap;
        void'($urandom(32'h910bbf3a));
        rst       = 1'b1;
        in_valid  = 1'b0;
        inst0     = 32'd0;
        inst1     = 32'd0;
        cycles    = 0;
        err_count = 0;
        n_pass    = 0;
        n_fail    = 0;
        test_bad  = 1'b0;
        read_patterns();
        cycle_limit = RESET_CYCLES + 5 * pats.size() + 50;

        cur_test = "reset";
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compare_value("out_valid", 32'(1'b0), 32'(out_valid));
            compare_value("dual_issue", 32'(1'b0), 32'(dual_issue));
        end
        compare_value("w_ena0", 32'(1'b0), 32'(w_ena0));
        compare_value("w_dst0", 32'(5'd0), 32'(w_dst0));
        compare_value("cls0", 32'(11'd0), 32'(cls0));
        compare_value("w_ena1", 32'(1'b0), 32'(w_ena1));
        compare_value("w_dst1", 32'(5'd0), 32'(w_dst1));
        compare_value("cls1", 32'(11'd0), 32'(cls1));
        rst = 1'b0;
        @(negedge clk);
        compare_value("out_valid", 32'(1'b0), 32'(out_valid));   // first edge after reset.
        compare_value("dual_issue", 32'(1'b0), 32'(dual_issue));
        report_test();

        // pairs go back to back, a gap only now and then.
        for (int i = 0; i < pats.size(); i++) begin
            if (i % 3 == 2) begin
                gap = $urandom % 4;
                if (gap != 0) begin
                    idle_gap(gap, pats[i-1]);
                end
            end
            in_valid = 1'b1;
            inst0    = pats[i].inst0;
            inst1    = pats[i].inst1;
            @(negedge clk);
            cur_test = names[i];
            check_outputs(pats[i]);
            report_test();
        end
        in_valid = 1'b0;

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 n_pass, n_fail, err_count);
        if (n_fail == 0 && err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: logic/dual_decode_top.sv
module dual_decode_top
    import decode_pkg::*;
#(
    parameter bit TLB_EN = 1'b1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  logic [31:0]      inst0,      // older word.
    input  logic [31:0]      inst1,
    output logic             out_valid,
    output logic             dual_issue,
    output logic             w_ena0,
    output logic [4:0]       w_dst0,
    output logic [CLS_W-1:0] cls0,
    output logic             w_ena1,
    output logic [4:0]       w_dst1,
    output logic [CLS_W-1:0] cls1
);

    decode_if slot0_if ();
    decode_if slot1_if ();

    inst_decoder #(
        .TLB_EN(TLB_EN)
    ) dec0 (
        .inst (inst0),
        .res  (slot0_if)
    );

    inst_decoder #(
        .TLB_EN(TLB_EN)
    ) dec1 (
        .inst (inst1),
        .res  (slot1_if)
    );

    issue_pair pairer (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .slot0      (slot0_if),
        .slot1      (slot1_if),
        .out_valid  (out_valid),
        .dual_issue (dual_issue),
        .w_ena0     (w_ena0),
        .w_dst0     (w_dst0),
        .cls0       (cls0),
        .w_ena1     (w_ena1),
        .w_dst1     (w_dst1),
        .cls1       (cls1)
    );

endmodule

// File: logic/issue_pair.sv
module issue_pair
    import decode_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    decode_if.consumer       slot0,
    decode_if.consumer       slot1,
    output logic             out_valid,
    output logic             dual_issue,
    output logic             w_ena0,
    output logic [4:0]       w_dst0,
    output logic [CLS_W-1:0] cls0,
    output logic             w_ena1,
    output logic [4:0]       w_dst1,
    output logic [CLS_W-1:0] cls1
);

    // words that must issue alone.
    function automatic logic is_solo(input logic [CLS_W-1:0] cls);
        return cls[CLS_COP0] | cls[CLS_TLB] | cls[CLS_CACHE] | cls[CLS_RI];
    endfunction

    function automatic logic is_muldiv(input logic [CLS_W-1:0] cls);
        return cls[CLS_MUL] | cls[CLS_HILO];
    endfunction

    // ~~~~~~~~~~ pairing rules ~~~~
    wire raw_rs  = slot0.w_reg_ena & (slot0.w_reg_dst == slot1.rs);
    wire raw_rt  = slot0.w_reg_ena & (slot0.w_reg_dst == slot1.rt);
    wire both_ls = slot0.cls[CLS_LS] & slot1.cls[CLS_LS];   // one memory port.
    wire both_md = is_muldiv(slot0.cls) & is_muldiv(slot1.cls);
    wire ctrl1   = slot1.cls[CLS_BRANCH] | slot1.cls[CLS_J_IMME] | slot1.cls[CLS_JR];

    wire pair_ok = in_valid & ~raw_rs & ~raw_rt & ~both_ls & ~both_md &
                   ~is_solo(slot0.cls) & ~is_solo(slot1.cls) & ~ctrl1;

    // ~~~~~~~~~~ output stage ~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            dual_issue <= 1'b0;
            w_ena0     <= 1'b0;
            w_dst0     <= 5'd0;
            cls0       <= '0;
            w_ena1     <= 1'b0;
            w_dst1     <= 5'd0;
            cls1       <= '0;
        end else begin
            out_valid  <= in_valid;
            dual_issue <= pair_ok;
            if (in_valid) begin
                w_ena0 <= slot0.w_reg_ena;
                w_dst0 <= slot0.w_reg_dst;
                cls0   <= slot0.cls;
                w_ena1 <= slot1.w_reg_ena;
                w_dst1 <= slot1.w_reg_dst;
                cls1   <= slot1.cls;
            end
        end
    end

endmodule

// File: logic/inst_decoder.sv
module inst_decoder
    import decode_pkg::*;
#(
    parameter bit TLB_EN = 1'b1
) (
    input  inst_word_u  inst,
    decode_if.producer  res
);

    logic [5:0] op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [5:0] funct;
    logic [4:0] w_dst;

    assign op    = inst.i_view.op;
    assign rs    = inst.i_view.rs;
    assign rt    = inst.i_view.rt;
    assign rd    = inst.r_view.rd;     // same word, read as R format.
    assign funct = inst.r_view.funct;

    // ~~~~~~~~~~ opcode groups ~~~~
    wire is_special  = (op == OP_SPECIAL);
    wire is_special2 = (op == OP_SPECIAL2);
    wire is_regimm   = (op == OP_REGIMM);
    wire is_cop0     = (op == OP_COP0);
    wire op_j        = (op == OP_J);
    wire op_jal      = (op == OP_JAL);
    wire op_cache    = (op == OP_CACHE);
    wire op_alu_imm  = op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                                  OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    wire op_load     = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWL, OP_LWR};
    wire op_store    = op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
    wire op_cbranch  = op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ};

    // ~~~~~~~~~~ funct groups ~~~~~
    wire fn_alu     = funct inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
                                    FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SRL,
                                    FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
    wire fn_mf_hilo = funct inside {FN_MFHI, FN_MFLO};
    wire fn_hilo_w  = funct inside {FN_MTHI, FN_MTLO, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU};
    wire fn_jr      = (funct == FN_JR);
    wire fn_jalr    = (funct == FN_JALR);
    wire fn_trap    = funct inside {FN_SYSCALL, FN_BREAK};
    wire fn_ov      = funct inside {FN_ADD, FN_SUB};   // addu and subu never trap.
    wire sp_known   = is_special & (fn_alu | fn_mf_hilo | fn_hilo_w | fn_jr | fn_jalr | fn_trap);
    wire sp2_mul    = is_special2 & (funct == FN_MUL);

    // regimm forms, rt selects the condition.
    wire rim_plain  = is_regimm & (rt inside {RT_BLTZ, RT_BGEZ});
    wire rim_link   = is_regimm & (rt inside {RT_BLTZAL, RT_BGEZAL});  // bal included.

    // cop0 moves and the co form words.
    wire c0_mfc0    = is_cop0 & (rs == RS_MFC0);
    wire c0_mtc0    = is_cop0 & (rs == RS_MTC0);
    wire c0_co      = is_cop0 & (rs == RS_CO) & (rt == 5'd0) & (rd == 5'd0) &
                      (inst.r_view.sa == 5'd0);
    wire c0_eret    = c0_co & (funct == FN_ERET);
    wire c0_tlb     = TLB_EN & c0_co & (funct inside {FN_TLBP, FN_TLBR, FN_TLBWI});

    // ~~~~~~~~~~ write target ~~~~~
    always_comb begin
        if ((is_special & (fn_alu | fn_jalr | fn_mf_hilo)) | sp2_mul) begin
            w_dst = rd;
        end else if (op_alu_imm | op_load | c0_mfc0) begin
            w_dst = rt;
        end else if (op_jal | rim_link) begin
            w_dst = LINK_REG;        // implicit return address.
        end else begin
            w_dst = 5'd0;            // stores, branches, hi/lo writes, mtc0, tlb.
        end
    end

    assign res.rs        = rs;
    assign res.rt        = rt;
    assign res.w_reg_dst = w_dst;
    assign res.w_reg_ena = (w_dst != 5'd0);   // r0 writes are dropped.

    // ~~~~~~~~~~ class flags ~~~~~~
    assign res.cls[CLS_BRANCH]   = op_cbranch | is_regimm;
    assign res.cls[CLS_J_IMME]   = op_j | op_jal;
    assign res.cls[CLS_JR]       = is_special & (fn_jr | fn_jalr);
    assign res.cls[CLS_LS]       = op_load | op_store;
    assign res.cls[CLS_MUL]      = sp2_mul;
    assign res.cls[CLS_HILO]     = is_special & (fn_mf_hilo | fn_hilo_w);
    assign res.cls[CLS_COP0]     = is_cop0 | (is_special & fn_trap);
    assign res.cls[CLS_TLB]      = c0_tlb;
    assign res.cls[CLS_CACHE]    = op_cache;
    assign res.cls[CLS_CHECK_OV] = (is_special & fn_ov) | (op == OP_ADDI);

    // anything not matched above is reserved.
    assign res.cls[CLS_RI] = ~(sp_known | sp2_mul | rim_plain | rim_link |
                               c0_mfc0 | c0_mtc0 | c0_eret | c0_tlb |
                               op_alu_imm | op_load | op_store | op_cbranch |
                               op_j | op_jal | op_cache);

endmodule

// File: logic/decode_if.sv
interface decode_if
    import decode_pkg::*;
();
    logic [4:0]       rs;         // raw fields, whatever the format.
    logic [4:0]       rt;
    logic             w_reg_ena;
    logic [4:0]       w_reg_dst;
    logic [CLS_W-1:0] cls;

    modport producer (
        output rs,
        output rt,
        output w_reg_ena,
        output w_reg_dst,
        output cls
    );

    modport consumer (
        input rs,
        input rt,
        input w_reg_ena,
        input w_reg_dst,
        input cls
    );

endinterface

// File: logic/decode_pkg.sv
package decode_pkg;

    // ~~~~~~~~~~ opcodes ~~~~~~~~~~
    localparam logic [5:0] OP_SPECIAL  = 6'h00;
    localparam logic [5:0] OP_REGIMM   = 6'h01;
    localparam logic [5:0] OP_J        = 6'h02;
    localparam logic [5:0] OP_JAL      = 6'h03;
    localparam logic [5:0] OP_BEQ      = 6'h04;
    localparam logic [5:0] OP_BNE      = 6'h05;
    localparam logic [5:0] OP_BLEZ     = 6'h06;
    localparam logic [5:0] OP_BGTZ     = 6'h07;
    localparam logic [5:0] OP_ADDI     = 6'h08;
    localparam logic [5:0] OP_ADDIU    = 6'h09;
    localparam logic [5:0] OP_SLTI     = 6'h0a;
    localparam logic [5:0] OP_SLTIU    = 6'h0b;
    localparam logic [5:0] OP_ANDI     = 6'h0c;
    localparam logic [5:0] OP_ORI      = 6'h0d;
    localparam logic [5:0] OP_XORI     = 6'h0e;
    localparam logic [5:0] OP_LUI      = 6'h0f;
    localparam logic [5:0] OP_COP0     = 6'h10;
    localparam logic [5:0] OP_SPECIAL2 = 6'h1c;
    localparam logic [5:0] OP_LB       = 6'h20;
    localparam logic [5:0] OP_LH       = 6'h21;
    localparam logic [5:0] OP_LWL      = 6'h22;
    localparam logic [5:0] OP_LW       = 6'h23;
    localparam logic [5:0] OP_LBU      = 6'h24;
    localparam logic [5:0] OP_LHU      = 6'h25;
    localparam logic [5:0] OP_LWR      = 6'h26;
    localparam logic [5:0] OP_SB       = 6'h28;
    localparam logic [5:0] OP_SH       = 6'h29;
    localparam logic [5:0] OP_SWL      = 6'h2a;
    localparam logic [5:0] OP_SW       = 6'h2b;
    localparam logic [5:0] OP_SWR      = 6'h2e;
    localparam logic [5:0] OP_CACHE    = 6'h2f;

    // ~~~~~~~~~~ funct codes ~~~~~~
    localparam logic [5:0] FN_SLL      = 6'h00;
    localparam logic [5:0] FN_SRL      = 6'h02;
    localparam logic [5:0] FN_SRA      = 6'h03;
    localparam logic [5:0] FN_SLLV     = 6'h04;
    localparam logic [5:0] FN_SRLV     = 6'h06;
    localparam logic [5:0] FN_SRAV     = 6'h07;
    localparam logic [5:0] FN_JR       = 6'h08;
    localparam logic [5:0] FN_JALR     = 6'h09;
    localparam logic [5:0] FN_SYSCALL  = 6'h0c;
    localparam logic [5:0] FN_BREAK    = 6'h0d;
    localparam logic [5:0] FN_MFHI     = 6'h10;
    localparam logic [5:0] FN_MTHI     = 6'h11;
    localparam logic [5:0] FN_MFLO     = 6'h12;
    localparam logic [5:0] FN_MTLO     = 6'h13;
    localparam logic [5:0] FN_MULT     = 6'h18;
    localparam logic [5:0] FN_MULTU    = 6'h19;
    localparam logic [5:0] FN_DIV      = 6'h1a;
    localparam logic [5:0] FN_DIVU     = 6'h1b;
    localparam logic [5:0] FN_ADD      = 6'h20;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUB      = 6'h22;
    localparam logic [5:0] FN_SUBU     = 6'h23;
    localparam logic [5:0] FN_AND      = 6'h24;
    localparam logic [5:0] FN_OR       = 6'h25;
    localparam logic [5:0] FN_XOR      = 6'h26;
    localparam logic [5:0] FN_NOR      = 6'h27;
    localparam logic [5:0] FN_SLT      = 6'h2a;
    localparam logic [5:0] FN_SLTU     = 6'h2b;
    localparam logic [5:0] FN_MUL      = 6'h02;  // under special2.
    localparam logic [5:0] FN_TLBR     = 6'h01;  // cop0 co form.
    localparam logic [5:0] FN_TLBWI    = 6'h02;
    localparam logic [5:0] FN_TLBP     = 6'h08;
    localparam logic [5:0] FN_ERET     = 6'h18;

    // ~~~~~~~~~~ rt / rs codes ~~~~
    localparam logic [4:0] RT_BLTZ     = 5'h00;
    localparam logic [4:0] RT_BGEZ     = 5'h01;
    localparam logic [4:0] RT_BLTZAL   = 5'h10;
    localparam logic [4:0] RT_BGEZAL   = 5'h11;
    localparam logic [4:0] RT_BAL      = 5'h11;  // bgezal with rs of zero.
    localparam logic [4:0] RS_MFC0     = 5'h00;
    localparam logic [4:0] RS_MTC0     = 5'h04;
    localparam logic [4:0] RS_CO       = 5'h10;

    // ~~~~~~~~~~ class flags ~~~~~~
    localparam int CLS_W        = 11;
    localparam int CLS_BRANCH   = 0;
    localparam int CLS_J_IMME   = 1;
    localparam int CLS_JR       = 2;
    localparam int CLS_LS       = 3;
    localparam int CLS_MUL      = 4;
    localparam int CLS_HILO     = 5;
    localparam int CLS_COP0     = 6;
    localparam int CLS_TLB      = 7;
    localparam int CLS_CACHE    = 8;
    localparam int CLS_CHECK_OV = 9;
    localparam int CLS_RI       = 10;

    localparam logic [4:0] LINK_REG = 5'd31;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target26;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
        j_fmt_t j_view;
    } inst_word_u;

endpackage
